/* include/cpu_consts.svh */
`ifndef cpuConstsSvh
`define cpuConstsSvh

// one-hot T-state codes, bit n-1 set for cycle n
`define tOne    7'b0000001
`define tTwo    7'b0000010
`define tThree  7'b0000100
`define tFour   7'b0001000
`define tFive   7'b0010000
`define tSix    7'b0100000
`define tSeven  7'b1000000

// T1 codes shown in the fetch cycle right after a branch ends
// all three keep the T1 bit and add a tag bit, so none is one-hot
`define t1NoBranch  7'b0000011  // branch not taken
`define t1BrNoCross 7'b0000101  // taken, same page
`define t1BrCross   7'b0001001  // taken, page crossed

// no T-state active
`define emptyT  7'b0000000

// opcode queue entries between fetch and timing
`define opQueueDepth 4

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // phase of the timing FSM
    typedef enum logic [1:0] {
        fsmInit,        // reset BRK sequence
        fsmFetch,       // T1, opcode being taken
        fsmExecNorm,    // ordinary instruction
        fsmExecBrk      // break, software or injected
    } fsmState;

    // timing classes, one per distinct cycle pattern
    typedef enum logic [2:0] {
        clsNop,
        clsLdaImm,
        clsLdaAbs,
        clsJmpAbs,
        clsBranch,
        clsBrk
    } opClass;

    // small opcode subset, anything else times like NOP
    function automatic opClass opDecode(input logic [7:0] op);
        opClass cls;
        case (op)
            8'h00: cls = clsBrk;
            8'hA9: cls = clsLdaImm;
            8'hAD: cls = clsLdaAbs;
            8'h4C: cls = clsJmpAbs;
            // BPL BMI BVC BVS BCC BCS BNE BEQ
            8'h10, 8'h30, 8'h50, 8'h70,
            8'h90, 8'hB0, 8'hD0, 8'hF0: cls = clsBranch;
            default: cls = clsNop;
        endcase
        return cls;
    endfunction

endpackage

/* rtl/opFetch.sv */
`timescale 1ns/1ps

module opFetch (
    input  logic       phi1,
    input  logic       rst,
    input  logic       memReq,
    input  logic [7:0] memData,
    input  logic       memTaken,
    input  logic       memCross,
    input  logic       full,
    output logic       memAck,
    output logic       pushValid,
    output logic [9:0] pushWord
);

    typedef enum logic {
        hsIdle,     // waiting for req
        hsAck       // ack up, waiting for req to drop
    } hsState;

    hsState hs;
    hsState hsNext;

    // word layout: taken, cross, opcode
    assign pushWord = {memTaken, memCross, memData};

    // push only on the edge that raises ack, so once per transfer
    assign pushValid = (hs == hsIdle) && memReq && !full;

    always_comb begin
        hsNext = hs;
        case (hs)
            hsIdle: begin
                if (memReq && !full) begin
                    hsNext = hsAck;
                end
            end
            hsAck: begin
                if (!memReq) begin  // phase 3 seen, release ack
                    hsNext = hsIdle;
                end
            end
            default: hsNext = hsIdle;
        endcase
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            hs <= hsIdle;
        end else begin
            hs <= hsNext;
        end
    end

    // ack is just the state, so it is glitch free
    assign memAck = (hs == hsAck);

endmodule

/* rtl/opQueue.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module opQueue (
    input  logic       phi1,
    input  logic       rst,
    input  logic       pushValid,
    input  logic [9:0] pushWord,
    input  logic       pop,
    output logic [9:0] headWord,
    output logic       empty,
    output logic       full
);

    localparam int ptrW = $clog2(`opQueueDepth);
    localparam int cntW = ptrW + 1;
    localparam logic [ptrW-1:0] lastPtr = ptrW'(`opQueueDepth - 1);
    localparam logic [cntW-1:0] depthCnt = cntW'(`opQueueDepth);

    logic [9:0] mem [0:`opQueueDepth-1];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;

    logic doPush;
    logic doPop;

    // requests against a full or empty queue are dropped
    assign doPush = pushValid && !full;
    assign doPop  = pop && !empty;

    always_ff @(posedge phi1) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge phi1) begin
        if (doPush) begin
            mem[wrPtr] <= pushWord;
        end
    end

    assign headWord = mem[rdPtr];
    assign empty    = (count == '0);
    assign full     = (count == depthCnt);

endmodule

/* rtl/tStateGen.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tStateGen (
    input  logic             phi1,
    input  logic             rst,
    input  logic [6:0]       currT,
    input  cpu_pkg::fsmState state,
    input  logic [9:0]       headWord,
    input  logic             empty,
    input  logic             irq,
    output logic [6:0]       nextT,
    output logic             brkNow,
    output logic             hold,
    output logic             pop,
    output logic             instDone,
    output logic [7:0]       doneOp
);

    import cpu_pkg::*;

    opClass     headClass;
    logic [2:0] headLen;
    logic [6:0] headMark;
    logic [2:0] curIdx;
    logic       isT1;
    logic       take;

    logic       fetched;    // opcode already taken for this T1
    logic       brkReg;
    logic [2:0] lenReg;
    logic [6:0] markReg;
    logic [7:0] opReg;
    logic       prevWasT1;
    logic       prevInit;

    assign isT1 = (currT == `tOne) || (currT == `t1NoBranch) ||
                  (currT == `t1BrNoCross) || (currT == `t1BrCross);

    // cycle count and end marker of the opcode at the queue head
    always_comb begin
        headClass = opDecode(headWord[7:0]);
        headMark  = `tOne;
        case (headClass)
            clsJmpAbs: headLen = 3'd3;
            clsLdaAbs: headLen = 3'd4;
            clsBrk:    headLen = 3'd7;
            clsBranch: begin
                if (!headWord[9]) begin
                    headLen  = 3'd2;
                    headMark = `t1NoBranch;
                end else if (!headWord[8]) begin
                    headLen  = 3'd3;
                    headMark = `t1BrNoCross;
                end else begin
                    headLen  = 3'd4;
                    headMark = `t1BrCross;
                end
            end
            default:   headLen = 3'd2;  // NOP, LDA imm
        endcase
    end

    always_comb begin
        case (currT)
            `tTwo:   curIdx = 3'd2;
            `tThree: curIdx = 3'd3;
            `tFour:  curIdx = 3'd4;
            `tFive:  curIdx = 3'd5;
            `tSix:   curIdx = 3'd6;
            `tSeven: curIdx = 3'd7;
            default: curIdx = 3'd0;
        endcase
    end

    // irq wins over the queue, an injected break needs no opcode
    assign take = isT1 && !fetched && (irq || !empty);
    assign pop  = isT1 && !fetched && !irq && !empty;
    assign hold = isT1 && !fetched && !irq && empty;

    assign brkNow = isT1 && (fetched ? brkReg : (irq || headClass == clsBrk));

    always_comb begin
        if (isT1) begin
            nextT = hold ? currT : `tTwo;
        end else if (curIdx == lenReg) begin
            nextT = markReg;                // last cycle, next fetch
        end else if (curIdx == 3'd0) begin
            nextT = `tOne;                  // lost code, restart at fetch
        end else begin
            nextT = currT << 1;
        end
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            fetched   <= 1'b0;
            brkReg    <= 1'b1;
            lenReg    <= 3'd7;      // reset runs as a BRK from T2
            markReg   <= `tOne;
            prevWasT1 <= 1'b1;
            prevInit  <= 1'b1;
        end else begin
            prevWasT1 <= isT1;
            prevInit  <= (state == fsmInit);
            if (take) begin
                fetched <= 1'b1;
                brkReg  <= irq || (headClass == clsBrk);
                lenReg  <= irq ? 3'd7 : headLen;
                markReg <= irq ? `tOne : headMark;
            end else if (!isT1) begin
                fetched <= 1'b0;
            end
        end
    end

    always_ff @(posedge phi1) begin
        if (take) begin
            opReg <= irq ? 8'h00 : headWord[7:0];
        end
    end

    // first cycle of a new T1 closes the previous instruction
    assign instDone = isT1 && !prevWasT1 && !prevInit;
    assign doneOp   = opReg;

endmodule

/* rtl/plaFsm.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module plaFsm (
    input  logic             phi1,
    input  logic             rst,
    input  logic             ready,
    input  logic [6:0]       nextT,
    input  logic             brkNow,
    output logic [6:0]       currT,
    output cpu_pkg::fsmState state,
    output logic             intHandled,
    output logic             rstAll
);

    import cpu_pkg::*;

    fsmState nextState;
    logic    nextIsT1;

    assign nextIsT1 = (nextT == `tOne) || (nextT == `t1NoBranch) ||
                      (nextT == `t1BrNoCross) || (nextT == `t1BrCross);

    always_comb begin
        nextState  = state;
        intHandled = 1'b0;
        case (state)
            fsmInit: begin
                if (nextIsT1) begin     // reset BRK sequence done
                    nextState  = fsmFetch;
                    intHandled = 1'b1;
                end
            end
            fsmFetch: begin
                // brkNow comes from the same cycle's decode
                if (brkNow) begin
                    nextState = fsmExecBrk;
                end else begin
                    nextState = fsmExecNorm;
                end
            end
            fsmExecNorm: begin
                if (nextIsT1) begin
                    nextState = fsmFetch;
                end
            end
            fsmExecBrk: begin
                if (nextIsT1) begin
                    nextState  = fsmFetch;
                    intHandled = 1'b1;  // vector fetched
                end
            end
            default: nextState = fsmInit;
        endcase
    end

    // only phi1 edges matter, nothing moves on phi2
    always_ff @(posedge phi1) begin
        if (rst) begin
            currT  <= `tTwo;    // T2 of the reset BRK
            state  <= fsmInit;
            rstAll <= 1'b1;
        end else begin
            rstAll <= 1'b0;
            if (ready) begin
                currT <= nextT;
                state <= nextState;
            end
        end
    end

endmodule

/* rtl/cpuTiming.sv */
`timescale 1ns/1ps

module cpuTiming (
    input  logic             phi1,
    input  logic             rst,
    input  logic             rdy,
    input  logic             irq,
    input  logic             memReq,
    input  logic [7:0]       memData,
    input  logic             memTaken,
    input  logic             memCross,
    output logic             memAck,
    output logic [6:0]       currT,
    output cpu_pkg::fsmState state,
    output logic             intHandled,
    output logic             rstAll,
    output logic             instDone,
    output logic [7:0]       doneOp
);

    logic       pushValid;
    logic [9:0] pushWord;
    logic       full;
    logic       empty;
    logic       pop;
    logic [9:0] headWord;
    logic [6:0] nextT;
    logic       brkNow;
    logic       hold;
    logic       ready;

    // an empty queue at fetch stalls like a low rdy
    assign ready = rdy && !hold;

    opFetch uFetch (
        .phi1      (phi1),
        .rst       (rst),
        .memReq    (memReq),
        .memData   (memData),
        .memTaken  (memTaken),
        .memCross  (memCross),
        .full      (full),
        .memAck    (memAck),
        .pushValid (pushValid),
        .pushWord  (pushWord)
    );

    opQueue uQueue (
        .phi1      (phi1),
        .rst       (rst),
        .pushValid (pushValid),
        .pushWord  (pushWord),
        .pop       (pop),
        .headWord  (headWord),
        .empty     (empty),
        .full      (full)
    );

    tStateGen uTGen (
        .phi1      (phi1),
        .rst       (rst),
        .currT     (currT),
        .state     (state),
        .headWord  (headWord),
        .empty     (empty),
        .irq       (irq),
        .nextT     (nextT),
        .brkNow    (brkNow),
        .hold      (hold),
        .pop       (pop),
        .instDone  (instDone),
        .doneOp    (doneOp)
    );

    plaFsm uFsm (
        .phi1       (phi1),
        .rst        (rst),
        .ready      (ready),
        .nextT      (nextT),
        .brkNow     (brkNow),
        .currT      (currT),
        .state      (state),
        .intHandled (intHandled),
        .rstAll     (rstAll)
    );

endmodule

/* tests/cpuTiming_assert.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTimingAssert (
    input logic             phi1,
    input logic             rst,
    input logic             rdy,
    input logic             hold,
    input logic             ready,
    input logic             full,
    input logic             pop,
    input logic [9:0]       headWord,
    input logic             memReq,
    input logic             memAck,
    input logic [6:0]       currT,
    input cpu_pkg::fsmState state,
    input logic             intHandled,
    input logic             rstAll,
    input logic             instDone,
    input logic [7:0]       doneOp
);

    import cpu_pkg::*;

    int errCount = 0;

    logic       inFlight;   // an instruction has been fetched
    logic       wordHeld;   // popped while rdy was low
    logic [9:0] heldWord;
    logic [9:0] fetchWord;
    logic       fetchAdv;
    logic       injAdv;
    logic [3:0] cycCnt;
    logic [3:0] expLen;
    logic [6:0] expMark;
    logic [7:0] expOp;

    // cycle rule by class, branch length from its flags
    function automatic logic [3:0] ruleLength(input logic [9:0] word);
        case (opDecode(word[7:0]))
            clsJmpAbs: return 4'd3;
            clsLdaAbs: return 4'd4;
            clsBrk:    return 4'd7;
            clsBranch: return !word[9] ? 4'd2 : (!word[8] ? 4'd3 : 4'd4);
            default:   return 4'd2;
        endcase
    endfunction

    function automatic logic [6:0] ruleMark(input logic [9:0] word);
        if (opDecode(word[7:0]) != clsBranch) begin
            return `tOne;
        end
        return !word[9] ? `t1NoBranch : (!word[8] ? `t1BrNoCross : `t1BrCross);
    endfunction

    task automatic countFail(input string msg);
        errCount++;
        $error("%s", msg);
    endtask

    assign fetchAdv  = (state == fsmFetch) && ready;
    assign injAdv    = fetchAdv && !pop && !wordHeld;   // nothing popped, irq break
    assign fetchWord = pop ? headWord : heldWord;

    always_ff @(posedge phi1) begin
        if (rst) begin
            inFlight <= 1'b0;
            wordHeld <= 1'b0;
            cycCnt   <= '0;
        end else begin
            if (pop) begin
                heldWord <= headWord;
                wordHeld <= 1'b1;
            end
            if (fetchAdv) begin
                inFlight <= 1'b1;
                wordHeld <= 1'b0;
                cycCnt   <= 4'd1;
                expLen   <= injAdv ? 4'd7 : ruleLength(fetchWord);
                expMark  <= injAdv ? `tOne : ruleMark(fetchWord);
                expOp    <= injAdv ? 8'h00 : fetchWord[7:0];
            end else if (ready && inFlight) begin
                cycCnt <= cycCnt + 1'b1;    // stalled cycles do not count
            end
        end
    end

    resetEntry: assert property (@(posedge phi1) $fell(rst) |->
        rstAll && currT == `tTwo && state == fsmInit)
        else countFail("reset did not leave the core in T2 of init with rstAll high");
    rstAllPulse: assert property (@(posedge phi1) disable iff (rst) rstAll |=> !rstAll)
        else countFail("rstAll stayed high longer than one cycle");
    intExit: assert property (@(posedge phi1) disable iff (rst)
        state == fsmFetch && $past(state) inside {fsmInit, fsmExecBrk} |-> $past(intHandled))
        else countFail("reset or break sequence ended without intHandled");
    intOnce: assert property (@(posedge phi1) disable iff (rst) intHandled && ready |=> !intHandled)
        else countFail("intHandled stayed high after the sequence ended");
    lengthRule: assert property (@(posedge phi1) disable iff (rst)
        instDone |-> inFlight && cycCnt == expLen)
        else countFail($sformatf("[FAIL] cycCnt %h expected %h",
            $sampled(cycCnt), $sampled(expLen)));
    markerRule: assert property (@(posedge phi1) disable iff (rst) instDone |-> currT == expMark)
        else countFail($sformatf("[FAIL] currT %h expected %h",
            $sampled(currT), $sampled(expMark)));
    orderRule: assert property (@(posedge phi1) disable iff (rst) instDone |-> doneOp == expOp)
        else countFail($sformatf("[FAIL] doneOp %h expected %h",
            $sampled(doneOp), $sampled(expOp)));
    injBreak: assert property (@(posedge phi1) disable iff (rst) injAdv |=> state == fsmExecBrk)
        else countFail("pending irq at fetch did not start a break");
    ackRise: assert property (@(posedge phi1) disable iff (rst)
        $rose(memAck) |-> $past(memReq) && !$past(full))
        else countFail("memAck rose without a request or with the queue full");
    ackFall: assert property (@(posedge phi1) disable iff (rst) $fell(memAck) |-> !$past(memReq))
        else countFail("memAck fell while memReq was still high");
    stallHold: assert property (@(posedge phi1) disable iff (rst)
        !rdy || hold |=> $stable(currT) && $stable(state))
        else countFail("T-state or FSM state moved during a stall");

endmodule

/* tests/cpuTiming_tb.sv */
`timescale 1ns/1ps

module cpuTiming_tb;

    import cpu_pkg::*;

    localparam int numOps = 50;     // transfers sent over the whole run
    localparam int cyc = 4;

    logic        phi1 = 1'b0;
    logic        rst;
    logic        rdy;
    logic        irq;
    logic        memReq;
    logic [7:0]  memData;
    logic        memTaken;
    logic        memCross;
    logic        memAck;
    logic [6:0]  currT;
    fsmState     state;
    logic        intHandled;
    logic        rstAll;
    logic        instDone;
    logic [7:0]  doneOp;

    logic [31:0] seed = 32'h92fe3ecf;
    logic [7:0]  opTable [0:9] = '{8'h00, 8'hA9, 8'hAD, 8'h4C, 8'h10,
                                   8'h30, 8'hD0, 8'hF0, 8'hEA, 8'h02};
    logic [7:0]  expQ [$];
    int          errors = 0;
    int          irqCount = 0;
    int          injSeen = 0;

    cpuTiming dut (.*);

    bind cpuTiming cpuTimingAssert uAssert (.*);

    always #2 phi1 = ~phi1;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every drive happens 1 ns after a rising edge
    task automatic nextCycle();
        @(posedge phi1);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) nextCycle();
    endtask

    // one four-phase transfer of a random opcode and flags
    task automatic sendRandomOp();
        seed = lcgNext(seed);
        memData  = opTable[seed[27:24] % 10];
        memTaken = seed[13];
        memCross = seed[7];
        expQ.push_back(memData);
        memReq = 1'b1;
        do nextCycle(); while (!memAck);
        memReq = 1'b0;
        do nextCycle(); while (memAck);
    endtask

    // irq held until the break is under way, rdy is high here
    task automatic injectBreak();
        irq = 1'b1;
        irqCount++;
        while (state != fsmFetch) nextCycle();
        do nextCycle(); while (state != fsmExecBrk);
        irq = 1'b0;
    endtask

    task automatic stallPulses(input int n);
        for (int i = 0; i < n; i++) begin
            idle(3 + 4 * i);
            rdy = 1'b0;
            idle(2 + i);
            rdy = 1'b1;
        end
    endtask

    // retire check on the falling edge, outputs settled
    always @(negedge phi1) begin
        if (!rst && instDone) begin
            if (expQ.size() > 0 && expQ[0] == doneOp) begin
                expQ.delete(0);
            end else if (doneOp == 8'h00) begin
                injSeen++;  // break from irq
            end else if (expQ.size() == 0) begin
                errors++;
                $display("instruction retired with no opcode outstanding");
            end else begin
                errors++;
                $display("[FAIL] doneOp got %h expected %h", doneOp, expQ[0]);
                expQ.delete(0);
            end
        end
    end

    initial begin
        #(cyc * (40 * numOps + 400));
        $display("watchdog expired before all opcodes retired");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        rdy      = 1'b1;
        irq      = 1'b0;
        memReq   = 1'b0;
        memData  = 8'h00;
        memTaken = 1'b0;
        memCross = 1'b0;
        repeat (3) @(posedge phi1);
        #1;
        rst = 1'b0;
        repeat (16) begin   // gaps let the queue drain, hold shows up
            sendRandomOp();
            seed = lcgNext(seed);
            idle(seed[3:0]);
        end
        repeat (2) begin    // bursts outrun the consumer, back-pressure
            repeat (8) sendRandomOp();
            idle(3);
        end
        repeat (3) begin
            sendRandomOp();
            sendRandomOp();
            injectBreak();
            idle(6);
        end
        fork
            repeat (12) sendRandomOp();
            stallPulses(4);
        join
        while (expQ.size() != 0) nextCycle();
        idle(12);   // a last break may still be running
        if (injSeen != irqCount) begin
            errors++;
            $display("[FAIL] injected breaks got %0h expected %0h", injSeen, irqCount);
        end
        $display("errors: testbench %0d, assertions %0d", errors, dut.uAssert.errCount);
        if (errors == 0 && dut.uAssert.errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/opFetch.sv
rtl/opQueue.sv
rtl/tStateGen.sv
rtl/plaFsm.sv
rtl/cpuTiming.sv
tests/cpuTiming_assert.sv
tests/cpuTiming_tb.sv

/* Bender.yml */
package:
  name: cpu_timing

export_include_dirs:
  - include

sources:
  - rtl/cpu_pkg.sv
  - rtl/opFetch.sv
  - rtl/opQueue.sv
  - rtl/tStateGen.sv
  - rtl/plaFsm.sv
  - rtl/cpuTiming.sv
  - target: test
    files:
      - tests/cpuTiming_assert.sv
      - tests/cpuTiming_tb.sv
